/* Bender.yml */
package:
  name: logic_scope

sources:
  - common/scope_pkg.sv
  - common/draw_pkg.sv
  - capture/sample_timer.sv
  - capture/capture_buffer.sv
  - verilog/apb_regs.sv
  - verilog/trace_draw_fsm.sv
  - verilog/logic_scope_top.sv
  - target: test
    files:
      - verification/logic_scope_chk.sv
      - verification/logic_scope_tb.sv

/* capture/capture_buffer.sv */
`timescale 1ns/1ns

module capture_buffer (
    input  logic               clk,
    input  logic               arstn_sync,
    input  scope_pkg::probes_t probes,
    input  logic               sample_en,
    input  logic               cap_start,
    output logic               cap_busy,
    output logic               cap_done,
    input  logic [2:0]         rd_wave,
    input  scope_pkg::step_t   rd_step,
    output logic               rd_bit
);

    // one shift register per channel, newest sample at the top index
    logic [scope_pkg::buf_samples-1:0] wave_dat [scope_pkg::num_waves];

    logic             trig;      // channel 0 has changed since the start
    logic             trig_hit;
    scope_pkg::step_t pos;       // post-trigger sample count

    // trigger on the first sample where channel 0 leaves its last level
    assign trig_hit = trig | (probes[0] != wave_dat[0][scope_pkg::buf_samples-1]);

    always_ff @(posedge clk) begin
        for (int w = 0; w < scope_pkg::num_waves; w++) begin
            if (cap_start) begin
                // preload with the idle level, so the old capture cannot trigger
                wave_dat[w] <= {scope_pkg::buf_samples{probes[w]}};
            end else if (cap_busy && sample_en) begin
                wave_dat[w] <= {probes[w], wave_dat[w][scope_pkg::buf_samples-1:1]};
            end
        end
    end

    always_ff @(posedge clk or negedge arstn_sync) begin
        if (!arstn_sync) begin
            cap_busy <= 1'b0;
            cap_done <= 1'b0;
            trig     <= 1'b0;
            pos      <= scope_pkg::step_t'(scope_pkg::pos_offs);
        end else if (cap_start) begin
            cap_busy <= 1'b1;
            cap_done <= 1'b0;
            trig     <= 1'b0;
            pos      <= scope_pkg::step_t'(scope_pkg::pos_offs);
        end else if (cap_busy && sample_en && trig_hit) begin
            trig <= 1'b1;
            pos  <= pos + 1'b1;
            // trigger edge now sits pos_offs samples from the old end
            if (pos == scope_pkg::step_t'(scope_pkg::buf_samples - 1)) begin
                cap_busy <= 1'b0;
                cap_done <= 1'b1;  // held until the next start
            end
        end
    end

    // combinational read port for the drawing FSM
    always_comb begin
        if (rd_wave < scope_pkg::num_waves && rd_step < scope_pkg::buf_samples) begin
            rd_bit = wave_dat[rd_wave][rd_step];
        end else begin
            rd_bit = 1'b0;
        end
    end

endmodule

/* capture/sample_timer.sv */
`timescale 1ns/1ns

module sample_timer (
    input  logic                       clk,
    input  logic                       arstn_sync,
    input  logic [scope_pkg::sel_w-1:0] rate_sel,
    output logic                       sample_en
);

    // largest divider is 2^(2^sel_w - 1), so one counter bit per select step
    logic [2**scope_pkg::sel_w-2:0] cnt;
    logic [2**scope_pkg::sel_w-2:0] mask;

    // free running prescaler
    always_ff @(posedge clk or negedge arstn_sync) begin
        if (!arstn_sync) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    // ones in the low rate_sel bits
    assign mask = ~({$bits(mask){1'b1}} << rate_sel);

    // strobe once the low bits wrap, every cycle when rate_sel is 0
    assign sample_en = ((cnt & mask) == mask);

endmodule

/* common/draw_pkg.sv */
package draw_pkg;

    typedef logic [15:0] coord_t;
    typedef logic [15:0] color_t;  // rgb565

    // panel is mounted sideways, x runs along the short edge
    localparam coord_t scr_width  = 16'd240;
    localparam coord_t scr_height = 16'd320;

    localparam coord_t top_ofs  = 16'd10;
    localparam coord_t left_ofs = 16'd60;   // room for channel labels

    localparam coord_t wave_height = 16'd17;
    localparam coord_t step_width  = 16'd5;   // pixels per sample
    localparam coord_t wave_pitch  = 16'd38;  // distance between channel base rows

    // lower edge of the trace area cleared before each pass
    localparam coord_t clr_xstart = 16'd51;

    localparam color_t trace_color = 16'hFFFF;
    localparam color_t back_color  = 16'h0000;

    // filled rectangle, inclusive corners
    typedef struct packed {
        color_t color;
        coord_t xstart;
        coord_t ystart;
        coord_t xend;
        coord_t yend;
    } draw_cmd_t;

endpackage

/* common/scope_pkg.sv */
package scope_pkg;

    // capture geometry
    localparam int num_waves   = 5;    // probe channels
    localparam int buf_samples = 120;  // samples kept per channel
    localparam int win_samples = 60;   // samples drawn per screen
    localparam int pos_offs    = 3;    // start value of the post-trigger counter
    localparam int step_w      = 7;
    localparam int max_scroll  = buf_samples - win_samples;

    localparam int sel_w = 3;  // rate select, divides by 2^rate_sel

    // register map, byte addresses
    localparam logic [3:0] reg_ctrl   = 4'h0;
    localparam logic [3:0] reg_scroll = 4'h4;
    localparam logic [3:0] reg_status = 4'h8;

    typedef logic [num_waves-1:0] probes_t;

    typedef logic [step_w-1:0] step_t;  // sample index into a channel

    // configuration from the register block to the datapath
    typedef struct packed {
        logic [sel_w-1:0] rate_sel;
        step_t            scroll;    // first sample shown on screen
    } scope_ctrl_t;

    typedef struct packed {
        logic cap_busy;
        logic cap_done;
        logic draw_busy;
    } scope_status_t;

endpackage

/* verification/logic_scope_chk.sv */
`timescale 1ns/1ns

module logic_scope_chk (
    input logic                clk,
    input logic                arstn_sync,
    input draw_pkg::draw_cmd_t cmd,
    input logic                cmd_valid,
    input logic                cmd_ready,
    input logic                cap_busy,
    input logic                cap_done
);

    int assert_fails = 0;  // failed assertion count

    // stalled command stays on the bus unchanged
    hold_under_backpressure: assert property (@(posedge clk) disable iff (!arstn_sync)
        cmd_valid && !cmd_ready |=> cmd_valid && $stable(cmd))
        else begin
            $error("cmd changed or dropped while stalled");
            assert_fails++;
        end

    no_valid_in_reset: assert property (@(posedge clk) !arstn_sync |-> !cmd_valid)
        else begin
            $error("cmd_valid high during reset");
            assert_fails++;
        end

    busy_done_exclusive: assert property (@(posedge clk) disable iff (!arstn_sync)
        !(cap_busy && cap_done))
        else begin
            $error("cap_busy and cap_done high together");
            assert_fails++;
        end

endmodule

bind logic_scope_top logic_scope_chk u_chk (
    .clk        (clk),
    .arstn_sync (arstn_sync),
    .cmd        (cmd),
    .cmd_valid  (cmd_valid),
    .cmd_ready  (cmd_ready),
    .cap_busy   (cap_busy),
    .cap_done   (cap_done)
);

/* verification/logic_scope_tb.sv */
`timescale 1ns/1ns

module logic_scope_tb;

    logic                clk;
    logic                arstn_sync;
    logic [3:0]          paddr;
    logic                psel;
    logic                penable;
    logic                pwrite;
    logic [31:0]         pwdata;
    logic [31:0]         prdata;
    scope_pkg::probes_t  probes;
    draw_pkg::draw_cmd_t cmd;
    logic                cmd_valid;
    logic                cmd_ready;

    logic [15:0]         gold [0:31];
    logic [119:0]        model [5];     // expected capture per channel
    draw_pkg::draw_cmd_t rx_q [$];
    draw_pkg::draw_cmd_t exp_q [$];
    int                  err_count;
    int                  tests_passed;
    int                  tests_failed;
    int                  cycles;
    int                  cycle_limit;
    logic                rand_ready;
    int unsigned         seed_val;
    logic [31:0]         rd;

    logic_scope_top u_dut (
        .clk(clk), .arstn_sync(arstn_sync), .paddr(paddr), .psel(psel),
        .penable(penable), .pwrite(pwrite), .pwdata(pwdata), .prdata(prdata),
        .probes(probes), .cmd(cmd), .cmd_valid(cmd_valid), .cmd_ready(cmd_ready)
    );

    always #4 clk = ~clk;

    // ready source, stall about one in four when randomized
    initial begin
        seed_val = $urandom(32'hc442);
        forever begin
            @(negedge clk);
            cmd_ready <= rand_ready ? ($urandom % 4 != 0) : 1'b1;
        end
    end

    // accepted commands
    always @(posedge clk) begin
        if (arstn_sync && cmd_valid && cmd_ready) rx_q.push_back(cmd);
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > cycle_limit) begin
            $display("Timeout: run did not finish within %0d cycles", cycle_limit);
            $display("Checks failed");
            $finish;
        end
    end

    task automatic check_value(input logic [79:0] got, input logic [79:0] exp,
                               input string msg);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, msg, got, exp);
            err_count++;
        end
    endtask

    task automatic apb_write(input logic [3:0] addr, input logic [31:0] data);
        @(negedge clk);
        psel   = 1'b1;
        pwrite = 1'b1;
        paddr  = addr;
        pwdata = data;
        @(negedge clk);
        penable = 1'b1;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input logic [3:0] addr, output logic [31:0] data);
        @(negedge clk);
        psel   = 1'b1;
        pwrite = 1'b0;
        paddr  = addr;
        @(negedge clk);
        penable = 1'b1;
        @(negedge clk);
        data    = prdata;  // access phase, mux is settled
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    // poll status until a drawing pass has started and ended
    task automatic wait_draw_done();
        logic [31:0] st;
        do apb_read(scope_pkg::reg_status, st); while (st[0] == 1'b0);
        do apb_read(scope_pkg::reg_status, st); while (st[0] == 1'b1);
    endtask

    // idle level first, then each golden run, every value held for hold cycles
    task automatic play_probes(input int hold);
        int n;
        for (n = 0; n < 8 * hold; n++) begin
            @(negedge clk) probes = '0;
        end
        for (int r = 0; r < gold[7]; r++) begin
            for (n = 0; n < gold[9 + 2 * r] * hold; n++) begin
                @(negedge clk) probes = gold[8 + 2 * r][4:0];
            end
        end
    endtask

    // trigger edge lands at index 3, idle level below it
    task automatic build_model();
        int idx;
        idx = 3;
        for (int w = 0; w < 5; w++) model[w] = '0;
        for (int r = 0; r < gold[7]; r++) begin
            for (int n = 0; n < gold[9 + 2 * r]; n++) begin
                if (idx < 120) begin
                    for (int w = 0; w < 5; w++) model[w][idx] = gold[8 + 2 * r][w];
                end
                idx++;
            end
        end
    endtask

    task automatic build_expected(input int scroll);
        int base;
        int last;
        int y;
        int lvl;
        exp_q.delete();
        exp_q.push_back('{16'h0000, 16'd51, 16'd60, 16'd229, 16'd319});
        last = (scroll + 60 > 119) ? 119 : scroll + 60;
        for (int w = 0; w < 5; w++) begin
            base = 229 - 38 * w;
            for (int i = scroll; i <= last; i++) begin
                y = 60 + 5 * (i - scroll);
                if (i > scroll && model[w][i] != model[w][i-1])
                    exp_q.push_back('{16'hFFFF, 16'(base - 17), 16'(y), 16'(base), 16'(y)});
                lvl = model[w][i] ? base : base - 17;
                exp_q.push_back('{16'hFFFF, 16'(lvl), 16'(y), 16'(lvl), 16'(y + 5)});
            end
        end
    endtask

    task automatic compare_stream(input int scroll, input int count, input string tag);
        int n;
        build_expected(scroll);
        check_value(rx_q.size(), count, {tag, " command count"});
        check_value(exp_q.size(), count, {tag, " model count"});
        n = (rx_q.size() < exp_q.size()) ? rx_q.size() : exp_q.size();
        for (int i = 0; i < n; i++) begin
            check_value(rx_q[i], exp_q[i], $sformatf("%s cmd %0d", tag, i));
        end
        rx_q.delete();
    endtask

    task automatic end_test(input int num, input string name, input int errs_before);
        if (err_count == errs_before) begin
            tests_passed++;
            $display("test %0d %s: pass", num, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: FAIL (%0d errors)", num, name, err_count - errs_before);
        end
    endtask

    task automatic capture_test(input int num, input string name, input int rate);
        int e;
        e = err_count;
        apb_write(scope_pkg::reg_ctrl, (rate << 1) | 1);
        play_probes(1 << rate);
        wait_draw_done();
        apb_read(scope_pkg::reg_status, rd);
        check_value(rd, gold[6], "status after capture");
        compare_stream(0, gold[4], name);
        end_test(num, name, e);
    endtask

    initial begin
        int e;
        int samples;
        clk          = 1'b0;
        arstn_sync   = 1'b0;
        paddr        = '0;
        psel         = 1'b0;
        penable      = 1'b0;
        pwrite       = 1'b0;
        pwdata       = '0;
        probes       = '0;
        cmd_ready    = 1'b1;
        rand_ready   = 1'b0;
        err_count    = 0;
        tests_passed = 0;
        tests_failed = 0;
        cycles       = 0;
        $readmemh("verification/scope_golden.txt", gold);
        build_model();
        samples = 8;  // idle lead-in
        for (int r = 0; r < gold[7]; r++) samples += gold[9 + 2 * r];
        // samples times 2^rate per capture plus four cycles per command, doubled
        cycle_limit = 2 * (6 * samples + 4 * (6 * int'(gold[4]) + int'(gold[5])));
        repeat (16) @(posedge clk);
        @(negedge clk) arstn_sync = 1'b1;

        e = err_count;
        apb_write(scope_pkg::reg_ctrl, gold[0] << 1);
        apb_read(scope_pkg::reg_ctrl, rd);
        check_value(rd, gold[0] << 1, "rate_sel readback");
        apb_write(scope_pkg::reg_scroll, gold[1]);
        wait_draw_done();
        apb_read(scope_pkg::reg_scroll, rd);
        check_value(rd, gold[2], "scroll saturation");
        apb_write(scope_pkg::reg_scroll, 0);
        wait_draw_done();
        rx_q.delete();  // passes over an empty buffer
        end_test(1, "register readback", e);

        capture_test(2, "capture rate 0", 0);

        e = err_count;
        apb_write(scope_pkg::reg_scroll, gold[3]);
        wait_draw_done();
        compare_stream(gold[3], gold[5], "scroll redraw");
        end_test(3, "scroll redraw", e);

        apb_write(scope_pkg::reg_scroll, 0);
        wait_draw_done();
        rx_q.delete();
        rand_ready = 1'b1;
        capture_test(4, "random ready", 0);
        rand_ready = 1'b0;

        capture_test(5, "capture rate 2", 2);

        $display("tests passed %0d, failed %0d, errors %0d, assertion failures %0d",
                 tests_passed, tests_failed, err_count, u_dut.u_chk.assert_fails);
        if (err_count == 0 && u_dut.u_chk.assert_fails == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* verification/scope_golden.txt */
// golden data for logic_scope_tb, one hex word per entry
// [0] rate_sel  [1] scroll write  [2] scroll readback  [3] redraw scroll
0005
0064
003C
0014
// [4] command count at scroll 0  [5] command count at scroll 20
013F
013A
// [6] status after a finished capture and pass (cap_done only)
0002
// [7] number of probe runs, then one run per line as probe value and sample count
0005
001F 0014
000A 001E
0015 001E
0000 0025
0000 000A

/* verilog.f */
common/scope_pkg.sv
common/draw_pkg.sv
capture/sample_timer.sv
capture/capture_buffer.sv
verilog/apb_regs.sv
verilog/trace_draw_fsm.sv
verilog/logic_scope_top.sv
verification/logic_scope_chk.sv
verification/logic_scope_tb.sv

/* verilog/apb_regs.sv */
`timescale 1ns/1ns

module apb_regs (
    input  logic                     clk,
    input  logic                     arstn_sync,
    input  logic [3:0]               paddr,
    input  logic                     psel,
    input  logic                     penable,
    input  logic                     pwrite,
    input  logic [31:0]              pwdata,
    output logic [31:0]              prdata,
    input  scope_pkg::scope_status_t status,
    output scope_pkg::scope_ctrl_t   cfg,
    output logic                     cap_start,
    output logic                     redraw
);

    logic access;
    logic wr_ctrl;
    logic wr_scroll;

    // no wait states, the access phase completes at once
    assign access    = psel & penable;
    assign wr_ctrl   = access & pwrite & (paddr == scope_pkg::reg_ctrl);
    assign wr_scroll = access & pwrite & (paddr == scope_pkg::reg_scroll);

    always_ff @(posedge clk or negedge arstn_sync) begin
        if (!arstn_sync) begin
            cfg       <= '0;
            cap_start <= 1'b0;
            redraw    <= 1'b0;
        end else begin
            // single cycle pulses
            cap_start <= 1'b0;
            redraw    <= 1'b0;

            if (wr_ctrl) begin
                cfg.rate_sel <= pwdata[scope_pkg::sel_w:1];
                cap_start    <= pwdata[0];
            end

            if (wr_scroll) begin
                if (pwdata > 32'(scope_pkg::max_scroll)) begin
                    cfg.scroll <= scope_pkg::step_t'(scope_pkg::max_scroll);
                end else begin
                    cfg.scroll <= pwdata[scope_pkg::step_w-1:0];
                end
                // a running capture redraws on its own when done
                redraw <= ~status.cap_busy;
            end
        end
    end

    // read mux
    always_comb begin
        prdata = '0;
        case (paddr)
            scope_pkg::reg_ctrl: begin
                prdata[scope_pkg::sel_w:1] = cfg.rate_sel;  // start bit reads 0
            end
            scope_pkg::reg_scroll: begin
                prdata[scope_pkg::step_w-1:0] = cfg.scroll;
            end
            scope_pkg::reg_status: begin
                prdata[$bits(status)-1:0] = status;
            end
            default: begin
                prdata = '0;
            end
        endcase
    end

endmodule

/* verilog/logic_scope_top.sv */
`timescale 1ns/1ns

module logic_scope_top (
    input  logic                clk,
    input  logic                arstn_sync,
    input  logic [3:0]          paddr,
    input  logic                psel,
    input  logic                penable,
    input  logic                pwrite,
    input  logic [31:0]         pwdata,
    output logic [31:0]         prdata,
    input  scope_pkg::probes_t  probes,
    output draw_pkg::draw_cmd_t cmd,
    output logic                cmd_valid,
    input  logic                cmd_ready
);

    scope_pkg::scope_ctrl_t   cfg;
    scope_pkg::scope_status_t status;
    logic                     cap_start;
    logic                     redraw;
    logic                     sample_en;
    logic                     cap_busy;
    logic                     cap_done;
    logic                     draw_busy;
    logic [2:0]               rd_wave;
    scope_pkg::step_t         rd_step;
    logic                     rd_bit;

    assign status = '{cap_busy, cap_done, draw_busy};

    apb_regs u_regs (
        .clk        (clk),
        .arstn_sync (arstn_sync),
        .paddr      (paddr),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .status     (status),
        .cfg        (cfg),
        .cap_start  (cap_start),
        .redraw     (redraw)
    );

    sample_timer u_timer (
        .clk        (clk),
        .arstn_sync (arstn_sync),
        .rate_sel   (cfg.rate_sel),
        .sample_en  (sample_en)
    );

    capture_buffer u_capture (
        .clk        (clk),
        .arstn_sync (arstn_sync),
        .probes     (probes),
        .sample_en  (sample_en),
        .cap_start  (cap_start),
        .cap_busy   (cap_busy),
        .cap_done   (cap_done),
        .rd_wave    (rd_wave),
        .rd_step    (rd_step),
        .rd_bit     (rd_bit)
    );

    trace_draw_fsm u_draw (
        .clk        (clk),
        .arstn_sync (arstn_sync),
        .cap_done   (cap_done),
        .redraw     (redraw),
        .scroll     (cfg.scroll),
        .rd_wave    (rd_wave),
        .rd_step    (rd_step),
        .rd_bit     (rd_bit),
        .cmd        (cmd),
        .cmd_valid  (cmd_valid),
        .cmd_ready  (cmd_ready),
        .draw_busy  (draw_busy)
    );

endmodule

/* verilog/trace_draw_fsm.sv */
`timescale 1ns/1ns

module trace_draw_fsm (
    input  logic                clk,
    input  logic                arstn_sync,
    input  logic                cap_done,
    input  logic                redraw,
    input  scope_pkg::step_t    scroll,
    output logic [2:0]          rd_wave,
    output scope_pkg::step_t    rd_step,
    input  logic                rd_bit,
    output draw_pkg::draw_cmd_t cmd,
    output logic                cmd_valid,
    input  logic                cmd_ready,
    output logic                draw_busy
);

    typedef enum logic [2:0] {
        st_idle,
        st_clear,
        st_horiz,
        st_vert,
        st_next
    } state_t;

    state_t                       state;
    logic [2:0]                   wave;
    scope_pkg::step_t             step;
    scope_pkg::step_t             win_start;  // scroll latched for the pass
    scope_pkg::step_t             last_step;
    logic [scope_pkg::step_w:0]   win_end;
    draw_pkg::coord_t             xbase;      // base row of the current wave
    draw_pkg::coord_t             ypos;
    logic                         cur_bit;
    logic                         prev_bit;
    logic                         done_q;
    logic                         pend;       // start seen during a pass
    logic                         start_req;

    // horizontal segment, high level on the base row
    function automatic draw_pkg::draw_cmd_t hline(input logic b, input draw_pkg::coord_t xb,
                                                  input draw_pkg::coord_t y);
        draw_pkg::coord_t lvl;
        lvl = b ? xb : xb - draw_pkg::wave_height;
        return '{draw_pkg::trace_color, lvl, y, lvl, y + draw_pkg::step_width};
    endfunction

    function automatic draw_pkg::draw_cmd_t vline(input draw_pkg::coord_t xb,
                                                  input draw_pkg::coord_t y);
        return '{draw_pkg::trace_color, xb - draw_pkg::wave_height, y, xb, y};
    endfunction

    assign start_req = (cap_done & ~done_q) | redraw;

    // window end clipped to the last stored sample
    assign win_end   = {1'b0, win_start} + (scope_pkg::step_w + 1)'(scope_pkg::win_samples);
    assign last_step = (win_end > (scope_pkg::step_w + 1)'(scope_pkg::buf_samples - 1)) ?
                       scope_pkg::step_t'(scope_pkg::buf_samples - 1) :
                       win_end[scope_pkg::step_w-1:0];

    assign rd_wave   = wave;
    assign rd_step   = step;
    assign draw_busy = (state != st_idle);

    always_ff @(posedge clk or negedge arstn_sync) begin
        if (!arstn_sync) begin
            state     <= st_idle;
            cmd       <= '0;
            cmd_valid <= 1'b0;
            wave      <= '0;
            step      <= '0;
            win_start <= '0;
            xbase     <= '0;
            ypos      <= '0;
            cur_bit   <= 1'b0;
            prev_bit  <= 1'b0;
            done_q    <= 1'b0;
            pend      <= 1'b0;
        end else begin
            done_q <= cap_done;
            if (start_req && state != st_idle) pend <= 1'b1;

            case (state)
                st_idle: begin
                    if (start_req || pend) begin
                        pend      <= 1'b0;
                        win_start <= scroll;
                        cmd       <= '{draw_pkg::back_color, draw_pkg::clr_xstart,
                                       draw_pkg::left_ofs,
                                       draw_pkg::scr_width - 1'b1 - draw_pkg::top_ofs,
                                       draw_pkg::scr_height - 1'b1};
                        cmd_valid <= 1'b1;
                        state     <= st_clear;
                    end
                end
                st_clear: begin
                    if (cmd_ready) begin
                        cmd_valid <= 1'b0;
                        wave      <= '0;
                        step      <= win_start;
                        xbase     <= draw_pkg::scr_width - 1'b1 - draw_pkg::top_ofs;
                        ypos      <= draw_pkg::left_ofs;
                        state     <= st_next;
                    end
                end
                // rd_bit now holds the sample at step
                st_next: begin
                    cur_bit   <= rd_bit;
                    cmd_valid <= 1'b1;
                    if (step != win_start && rd_bit != prev_bit) begin
                        cmd   <= vline(xbase, ypos);  // edge first
                        state <= st_vert;
                    end else begin
                        cmd   <= hline(rd_bit, xbase, ypos);
                        state <= st_horiz;
                    end
                end
                st_vert: begin
                    if (cmd_ready) begin
                        cmd   <= hline(cur_bit, xbase, ypos);
                        state <= st_horiz;
                    end
                end
                st_horiz: begin
                    if (cmd_ready) begin
                        cmd_valid <= 1'b0;
                        prev_bit  <= cur_bit;
                        if (step == last_step) begin
                            if (wave == 3'(scope_pkg::num_waves - 1)) begin
                                state <= st_idle;
                            end else begin
                                // next channel one pitch further down
                                wave  <= wave + 1'b1;
                                step  <= win_start;
                                xbase <= xbase - draw_pkg::wave_pitch;
                                ypos  <= draw_pkg::left_ofs;
                                state <= st_next;
                            end
                        end else begin
                            step  <= step + 1'b1;
                            ypos  <= ypos + draw_pkg::step_width;
                            state <= st_next;
                        end
                    end
                end
                default: begin
                    cmd_valid <= 1'b0;
                    state     <= st_idle;
                end
            endcase
        end
    end

endmodule
